/* hw/axi_bridge_pkg.sv */
`default_nettype none

package axi_bridge_pkg;

    parameter int unsigned ADDR_W = 32;
    parameter int unsigned DATA_W = 32;
    parameter int unsigned LINE_W = 128;

    // byte 0, half 1, word 2 go straight onto the AXI size field
    typedef logic [2:0] req_type_t;

    parameter req_type_t TYPE_LINE = 3'd4;

    parameter int unsigned LINE_BEATS = 4;
    parameter logic [7:0]  LINE_LEN   = 8'd3;   // beats - 1
    parameter logic [2:0]  WORD_SIZE  = 3'd2;   // 4 bytes per beat

    parameter logic ID_INST = 1'b0;
    parameter logic ID_DATA = 1'b1;

    function automatic logic [2:0] axi_size(req_type_t t);
        return (t == TYPE_LINE) ? WORD_SIZE : t;
    endfunction

    function automatic logic [7:0] axi_len(req_type_t t);
        return (t == TYPE_LINE) ? LINE_LEN : 8'd0;
    endfunction

endpackage

`default_nettype wire

/* hw/axi_read_path.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_read_path (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              inst_rd_req,
    input  axi_bridge_pkg::req_type_t         inst_rd_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] inst_rd_addr,
    output logic                              inst_rd_rdy,
    output logic                              inst_ret_valid,
    output logic                              inst_ret_last,
    output logic [axi_bridge_pkg::DATA_W-1:0] inst_ret_data,

    input  logic                              data_rd_req,
    input  axi_bridge_pkg::req_type_t         data_rd_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] data_rd_addr,
    output logic                              data_rd_rdy,
    output logic                              data_ret_valid,
    output logic                              data_ret_last,
    output logic [axi_bridge_pkg::DATA_W-1:0] data_ret_data,

    input  logic                              write_block,

    output logic                              arid,
    output logic [axi_bridge_pkg::ADDR_W-1:0] araddr,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic                              arvalid,
    input  logic                              arready,

    input  logic                              rid,
    input  logic [axi_bridge_pkg::DATA_W-1:0] rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready
);

    logic inst_busy;    // inst read in flight on AXI
    logic data_busy;
    logic slot_free;
    logic data_take;
    logic inst_take;
    logic ar_hs;
    logic r_last_hs;

    // a held write response stops new reads so they see the written data
    assign slot_free = !arvalid && !write_block;

    assign data_rd_rdy = slot_free && !data_busy;
    // data wins when both ask in the same cycle
    assign inst_rd_rdy = slot_free && !inst_busy && !(data_rd_req && !data_busy);

    assign data_take = data_rd_req && data_rd_rdy;
    assign inst_take = inst_rd_req && inst_rd_rdy;

    assign ar_hs     = arvalid && arready;
    assign r_last_hs = rvalid && rready && rlast;

    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid <= 1'b0;
        end else if (arvalid) begin
            if (arready)
                arvalid <= 1'b0;
        end else if (data_take || inst_take) begin
            arvalid <= 1'b1;
        end
    end

    // slot payload, only loaded while the slot is empty
    always_ff @(posedge clk) begin
        if (data_take) begin
            arid   <= axi_bridge_pkg::ID_DATA;
            araddr <= data_rd_addr;
            arsize <= axi_bridge_pkg::axi_size(data_rd_type);
            arlen  <= axi_bridge_pkg::axi_len(data_rd_type);
        end else if (inst_take) begin
            arid   <= axi_bridge_pkg::ID_INST;
            araddr <= inst_rd_addr;
            arsize <= axi_bridge_pkg::axi_size(inst_rd_type);
            arlen  <= axi_bridge_pkg::axi_len(inst_rd_type);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (ar_hs && arid == axi_bridge_pkg::ID_INST)
                inst_busy <= 1'b1;
            else if (r_last_hs && rid == axi_bridge_pkg::ID_INST)
                inst_busy <= 1'b0;

            if (ar_hs && arid == axi_bridge_pkg::ID_DATA)
                data_busy <= 1'b1;
            else if (r_last_hs && rid == axi_bridge_pkg::ID_DATA)
                data_busy <= 1'b0;
        end
    end

    // steer each beat by id, the other side sees zero
    always_comb begin
        inst_ret_valid = 1'b0;
        inst_ret_last  = 1'b0;
        inst_ret_data  = '0;
        data_ret_valid = 1'b0;
        data_ret_last  = 1'b0;
        data_ret_data  = '0;
        if (rid == axi_bridge_pkg::ID_DATA) begin
            data_ret_valid = rvalid;
            data_ret_last  = rvalid && rlast;
            data_ret_data  = rdata;
        end else begin
            inst_ret_valid = rvalid;
            inst_ret_last  = rvalid && rlast;
            inst_ret_data  = rdata;
        end
    end

endmodule

`default_nettype wire

/* hw/axi_write_path.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_write_path (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              data_wr_req,
    input  axi_bridge_pkg::req_type_t         data_wr_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] data_wr_addr,
    input  logic [3:0]                        data_wr_wstrb,
    input  logic [axi_bridge_pkg::LINE_W-1:0] data_wr_data,
    output logic                              data_wr_rdy,

    output logic [axi_bridge_pkg::ADDR_W-1:0] awaddr,
    output logic [7:0]                        awlen,
    output logic [2:0]                        awsize,
    output logic                              awvalid,
    input  logic                              awready,

    output logic [axi_bridge_pkg::DATA_W-1:0] wdata,
    output logic [3:0]                        wstrb,
    output logic                              wvalid,
    output logic                              wlast,
    input  logic                              wready,

    input  logic                              bvalid,
    output logic                              bready,

    output logic                              write_block,
    output logic                              write_buffer_empty
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR_DATA,   // address and first beat both outstanding
        ST_DATA,        // address taken, beats left
        ST_ADDR         // all beats taken, address still waiting
    } wr_state_t;

    wr_state_t state;

    logic [axi_bridge_pkg::LINE_W-axi_bridge_pkg::DATA_W-1:0] line_buf;
    logic [1:0] beats_left;
    logic [1:0] resp_cnt;   // bursts sent, B not yet seen
    logic       wr_take;
    logic       is_line;
    logic       aw_hs;
    logic       w_hs;
    logic       last_hs;
    logic       b_hs;

    assign is_line = (data_wr_type == axi_bridge_pkg::TYPE_LINE);

    assign awvalid = (state == ST_ADDR_DATA) || (state == ST_ADDR);
    assign wvalid  = (state == ST_ADDR_DATA) || (state == ST_DATA);
    assign bready  = 1'b1;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign last_hs = w_hs && wlast;
    assign b_hs    = bvalid && bready;

    // counter saturates at 3 outstanding bursts
    assign data_wr_rdy = (state == ST_IDLE) && (resp_cnt != 2'd3);
    assign wr_take     = data_wr_req && data_wr_rdy;

    assign write_buffer_empty = (state == ST_IDLE) && (resp_cnt == 2'd0);

    // drops in the cycle the last outstanding response is taken
    always_comb begin
        if (state != ST_IDLE)
            write_block = 1'b1;
        else if (resp_cnt == 2'd1)
            write_block = !b_hs;
        else
            write_block = (resp_cnt != 2'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_take)
                        state <= ST_ADDR_DATA;
                end
                ST_ADDR_DATA: begin
                    if (aw_hs && last_hs)
                        state <= ST_IDLE;
                    else if (aw_hs)
                        state <= ST_DATA;
                    else if (last_hs)
                        state <= ST_ADDR;
                end
                ST_DATA: begin
                    if (last_hs)
                        state <= ST_IDLE;
                end
                ST_ADDR: begin
                    if (aw_hs)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wlast      <= 1'b0;
            beats_left <= 2'd0;
        end else if (wr_take) begin
            wlast      <= !is_line;
            beats_left <= is_line ? 2'(axi_bridge_pkg::LINE_BEATS - 1) : 2'd0;
        end else if (w_hs) begin
            if (wlast) begin
                wlast <= 1'b0;
            end else begin
                wlast      <= (beats_left == 2'd1);
                beats_left <= beats_left - 2'd1;
            end
        end
    end

    // payload, low word goes out first
    always_ff @(posedge clk) begin
        if (wr_take) begin
            awaddr   <= data_wr_addr;
            awsize   <= axi_bridge_pkg::axi_size(data_wr_type);
            awlen    <= axi_bridge_pkg::axi_len(data_wr_type);
            wdata    <= data_wr_data[axi_bridge_pkg::DATA_W-1:0];
            wstrb    <= is_line ? 4'hf : data_wr_wstrb;
            line_buf <= data_wr_data[axi_bridge_pkg::LINE_W-1:axi_bridge_pkg::DATA_W];
        end else if (w_hs && !wlast) begin
            wdata    <= line_buf[axi_bridge_pkg::DATA_W-1:0];
            line_buf <= line_buf >> axi_bridge_pkg::DATA_W;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp_cnt <= 2'd0;
        else if (last_hs && !b_hs)
            resp_cnt <= resp_cnt + 2'd1;
        else if (b_hs && !last_hs && resp_cnt != 2'd0)
            resp_cnt <= resp_cnt - 2'd1;
    end

endmodule

`default_nettype wire

/* hw/cache_axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_axi_bridge (
    input  logic                              clk,
    input  logic                              reset,

    // instruction cache read side
    input  logic                              inst_rd_req,
    input  axi_bridge_pkg::req_type_t         inst_rd_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] inst_rd_addr,
    output logic                              inst_rd_rdy,
    output logic                              inst_ret_valid,
    output logic                              inst_ret_last,
    output logic [axi_bridge_pkg::DATA_W-1:0] inst_ret_data,

    // data cache
    input  logic                              data_rd_req,
    input  axi_bridge_pkg::req_type_t         data_rd_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] data_rd_addr,
    output logic                              data_rd_rdy,
    output logic                              data_ret_valid,
    output logic                              data_ret_last,
    output logic [axi_bridge_pkg::DATA_W-1:0] data_ret_data,
    input  logic                              data_wr_req,
    input  axi_bridge_pkg::req_type_t         data_wr_type,
    input  logic [axi_bridge_pkg::ADDR_W-1:0] data_wr_addr,
    input  logic [3:0]                        data_wr_wstrb,
    input  logic [axi_bridge_pkg::LINE_W-1:0] data_wr_data,
    output logic                              data_wr_rdy,
    output logic                              write_buffer_empty,

    // AXI read
    output logic                              arid,
    output logic [axi_bridge_pkg::ADDR_W-1:0] araddr,
    output logic [7:0]                        arlen,
    output logic [2:0]                        arsize,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic                              rid,
    input  logic [axi_bridge_pkg::DATA_W-1:0] rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready,

    // AXI write, burst type and id are fixed on the memory side
    output logic [axi_bridge_pkg::ADDR_W-1:0] awaddr,
    output logic [7:0]                        awlen,
    output logic [2:0]                        awsize,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [axi_bridge_pkg::DATA_W-1:0] wdata,
    output logic [3:0]                        wstrb,
    output logic                              wvalid,
    output logic                              wlast,
    input  logic                              wready,
    input  logic                              bvalid,
    output logic                              bready
);

    logic write_block;  // reads wait behind unacknowledged writes

    axi_read_path u_read_path (
        .clk            (clk),
        .reset          (reset),
        .inst_rd_req    (inst_rd_req),
        .inst_rd_type   (inst_rd_type),
        .inst_rd_addr   (inst_rd_addr),
        .inst_rd_rdy    (inst_rd_rdy),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_last  (inst_ret_last),
        .inst_ret_data  (inst_ret_data),
        .data_rd_req    (data_rd_req),
        .data_rd_type   (data_rd_type),
        .data_rd_addr   (data_rd_addr),
        .data_rd_rdy    (data_rd_rdy),
        .data_ret_valid (data_ret_valid),
        .data_ret_last  (data_ret_last),
        .data_ret_data  (data_ret_data),
        .write_block    (write_block),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arvalid        (arvalid),
        .arready        (arready),
        .rid            (rid),
        .rdata          (rdata),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    axi_write_path u_write_path (
        .clk                (clk),
        .reset              (reset),
        .data_wr_req        (data_wr_req),
        .data_wr_type       (data_wr_type),
        .data_wr_addr       (data_wr_addr),
        .data_wr_wstrb      (data_wr_wstrb),
        .data_wr_data       (data_wr_data),
        .data_wr_rdy        (data_wr_rdy),
        .awaddr             (awaddr),
        .awlen              (awlen),
        .awsize             (awsize),
        .awvalid            (awvalid),
        .awready            (awready),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .wvalid             (wvalid),
        .wlast              (wlast),
        .wready             (wready),
        .bvalid             (bvalid),
        .bready             (bready),
        .write_block        (write_block),
        .write_buffer_empty (write_buffer_empty)
    );

endmodule

`default_nettype wire

/* tests/axi_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        arid,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic        rid,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    input  logic        wlast,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);

    logic [31:0] mem [0:255];   // word index is addr[9:2]
    logic [31:0] rnd;           // fresh stall bits every cycle
    logic [31:0] wmask;
    logic        rd_busy;
    logic [7:0]  rd_idx;
    logic [7:0]  rd_left;       // beats after the current one
    logic        aw_taken;
    logic [7:0]  wr_idx;
    logic        b_pend;

    initial begin
        rnd <= $urandom(32'hf05b_e907);
        forever begin
            @(posedge clk);
            rnd <= $urandom;
        end
    end

    assign arready = !rd_busy && (rnd[1:0] != 2'd0);
    assign rvalid  = rd_busy && rnd[2];
    assign rdata   = mem[rd_idx];
    assign rlast   = (rd_left == 8'd0);
    // W beats only after the burst address is known
    assign awready = !aw_taken && !b_pend && rnd[3];
    assign wready  = aw_taken && rnd[4];
    assign bvalid  = b_pend && rnd[5];
    assign wmask   = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

    always @(posedge clk) begin
        if (reset) begin
            rd_busy  <= 1'b0;
            aw_taken <= 1'b0;
            b_pend   <= 1'b0;
            for (int i = 0; i < 256; i++)
                mem[i[7:0]] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c};
        end else begin
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rid     <= arid;
                rd_idx  <= araddr[9:2];
                rd_left <= arlen;
            end else if (rvalid && rready) begin
                rd_idx  <= rd_idx + 8'd1;
                rd_left <= rd_left - 8'd1;
                rd_busy <= !rlast;
            end
            if (awvalid && awready) begin
                aw_taken <= 1'b1;
                wr_idx   <= awaddr[9:2];
            end
            if (wvalid && wready) begin
                mem[wr_idx] <= (mem[wr_idx] & ~wmask) | (wdata & wmask);
                wr_idx      <= wr_idx + 8'd1;
                if (wlast) begin
                    aw_taken <= 1'b0;
                    b_pend   <= 1'b1;
                end
            end
            if (bvalid && bready)
                b_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_cache_axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_axi_bridge;

    localparam int TIMEOUT = 300;   // cycles allowed per wait

    logic clk, reset;
    logic inst_rd_req, inst_rd_rdy, inst_ret_valid, inst_ret_last;
    logic data_rd_req, data_rd_rdy, data_ret_valid, data_ret_last;
    logic data_wr_req, data_wr_rdy, write_buffer_empty;
    axi_bridge_pkg::req_type_t inst_rd_type, data_rd_type, data_wr_type;
    logic [31:0] inst_rd_addr, data_rd_addr, data_wr_addr, inst_ret_data, data_ret_data;
    logic [3:0] data_wr_wstrb, wstrb;
    logic [127:0] data_wr_data;
    logic arid, arvalid, arready, rid, rlast, rvalid, rready;
    logic awvalid, awready, wvalid, wlast, wready, bvalid, bready;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;

    logic [31:0] inst_beats[$], data_beats[$];
    logic        inst_lasts[$], data_lasts[$];
    logic [31:0] shadow [0:255];    // expected memory image
    logic [7:0]  exp_arlen [0:1];   // indexed by read id
    logic [7:0]  exp_awlen;

    cache_axi_bridge u_cache_axi_bridge (.*);
    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // return beats hold for the whole cycle so they are sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && inst_ret_valid) begin
            inst_beats.push_back(inst_ret_data);
            inst_lasts.push_back(inst_ret_last);
        end
        if (!reset && data_ret_valid) begin
            data_beats.push_back(data_ret_data);
            data_lasts.push_back(data_ret_last);
        end
    end

    // every request in these tests moves 4-byte beats
    always @(negedge clk) begin
        if (!reset && arvalid && arready) begin
            check_equal("ar length", 128'(exp_arlen[arid]), 128'(arlen));
            check_equal("ar size", 128'd2, 128'(arsize));
        end
        if (!reset && awvalid && awready) begin
            check_equal("aw length", 128'(exp_awlen), 128'(awlen));
            check_equal("aw size", 128'd2, 128'(awsize));
        end
        if (!reset && rvalid)
            check_equal("rready", 128'd1, 128'(rready));
        if (!reset && bvalid)
            check_equal("bready", 128'd1, 128'(bready));
    end

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch, stopping");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "wait limit reached");
    endtask

    function automatic logic [127:0] shadow_words(input logic [31:0] addr, input int beats);
        logic [127:0] w;
        w = '0;
        for (int k = 0; k < beats; k++)
            w = w | (128'(shadow[addr[9:2] + 8'(k)]) << (32 * k));
        return w;
    endfunction

    task automatic issue_read(input logic to_data, input axi_bridge_pkg::req_type_t t,
                              input logic [31:0] addr);
        int n;
        n = 0;
        if (to_data) begin
            data_rd_req  = 1'b1;
            data_rd_type = t;
            data_rd_addr = addr;
        end else begin
            inst_rd_req  = 1'b1;
            inst_rd_type = t;
            inst_rd_addr = addr;
        end
        @(negedge clk);
        while (!(to_data ? data_rd_rdy : inst_rd_rdy)) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("a read request to be accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (to_data)
            data_rd_req = 1'b0;
        else
            inst_rd_req = 1'b0;
    endtask

    task automatic collect_beats(input string name, input logic from_data, input int start,
                                 input int beats, output logic [127:0] got);
        int n;
        n = 0;
        got = '0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("read data to come back");
        end while ((from_data ? data_beats.size() : inst_beats.size()) < start + beats);
        #1;
        check_equal({name, " beat count"}, 128'(start + beats),
                    128'(from_data ? data_beats.size() : inst_beats.size()));
        for (int k = 0; k < beats; k++) begin
            got = got | (128'(from_data ? data_beats[start + k] : inst_beats[start + k])
                         << (32 * k));
            check_equal({name, " last"}, 128'(k == beats - 1),
                        128'(from_data ? data_lasts[start + k] : inst_lasts[start + k]));
        end
    endtask

    task automatic read_and_compare(input string name, input logic from_data,
                                    input axi_bridge_pkg::req_type_t t, input logic [31:0] addr,
                                    input int beats, output logic [127:0] got);
        int start;
        start = from_data ? data_beats.size() : inst_beats.size();
        exp_arlen[from_data] = 8'(beats - 1);
        issue_read(from_data, t, addr);
        collect_beats(name, from_data, start, beats, got);
        check_equal(name, shadow_words(addr, beats), got);
    endtask

    task automatic issue_write(input axi_bridge_pkg::req_type_t t, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [127:0] data);
        int n;
        logic [31:0] mask;
        n = 0;
        exp_awlen = (t == axi_bridge_pkg::TYPE_LINE) ? 8'd3 : 8'd0;   // four beats or one
        data_wr_req   = 1'b1;
        data_wr_type  = t;
        data_wr_addr  = addr;
        data_wr_wstrb = strb;
        data_wr_data  = data;
        @(negedge clk);
        while (!data_wr_rdy) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("the write request to be accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        data_wr_req = 1'b0;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (t == axi_bridge_pkg::TYPE_LINE) begin
            for (int k = 0; k < 4; k++)
                shadow[addr[9:2] + 8'(k)] = 32'(data >> (32 * k));
        end else begin
            shadow[addr[9:2]] = (shadow[addr[9:2]] & ~mask) | (data[31:0] & mask);
        end
    endtask

    task automatic wait_write_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (!write_buffer_empty) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("the write buffer to drain");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_data_word_read();
        int i0;
        logic [127:0] got;
        i0 = inst_beats.size();
        read_and_compare("data_word_read", 1'b1, 3'd2, 32'h0000_0040, 1, got);
        check_equal("data_word_read inst quiet", 128'(i0), 128'(inst_beats.size()));
    endtask

    task automatic test_inst_line_read();
        logic [127:0] got;
        read_and_compare("inst_line_read", 1'b0, axi_bridge_pkg::TYPE_LINE, 32'h0000_0100, 4, got);
    endtask

    task automatic test_line_write_readback();
        logic [127:0] got;
        issue_write(axi_bridge_pkg::TYPE_LINE, 32'h0000_0200, 4'hf,
                    128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
        wait_write_drain();
        read_and_compare("line_write_readback", 1'b1, axi_bridge_pkg::TYPE_LINE, 32'h0000_0200,
                         4, got);
        check_equal("line_write_readback", 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, got);
    endtask

    task automatic test_partial_word_write();
        logic [31:0] old;
        logic [127:0] got;
        old = shadow[33];
        issue_write(3'd2, 32'h0000_0084, 4'b0101, {96'd0, 32'hdead_beef});
        read_and_compare("partial_word_write", 1'b1, 3'd2, 32'h0000_0084, 1, got);
        check_equal("partial_word_write", {96'd0, old[31:24], 8'had, old[15:8], 8'hef}, got);
    endtask

    task automatic test_dual_line_read();
        int n, d0, i0;
        logic d_acc, i_acc;
        logic [127:0] dgot, igot;
        n = 0;
        d0 = data_beats.size();
        i0 = inst_beats.size();
        exp_arlen[0] = 8'd3;
        exp_arlen[1] = 8'd3;
        data_rd_req  = 1'b1;
        data_rd_type = axi_bridge_pkg::TYPE_LINE;
        data_rd_addr = 32'h0000_0300;
        inst_rd_req  = 1'b1;
        inst_rd_type = axi_bridge_pkg::TYPE_LINE;
        inst_rd_addr = 32'h0000_0140;
        while (data_rd_req || inst_rd_req) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("both line reads to be accepted");
            @(negedge clk);
            d_acc = data_rd_rdy;
            i_acc = inst_rd_rdy;
            @(posedge clk);
            #1;
            if (d_acc)
                data_rd_req = 1'b0;
            if (i_acc)
                inst_rd_req = 1'b0;
        end
        collect_beats("dual_read data", 1'b1, d0, 4, dgot);
        collect_beats("dual_read inst", 1'b0, i0, 4, igot);
        check_equal("dual_read data", shadow_words(32'h0000_0300, 4), dgot);
        check_equal("dual_read inst", shadow_words(32'h0000_0140, 4), igot);
    endtask

    task automatic test_read_after_write();
        logic [127:0] got;
        issue_write(axi_bridge_pkg::TYPE_LINE, 32'h0000_0200, 4'hf,
                    128'hcafe_f00d_1357_9bdf_2468_ace0_0f1e_2d3c);
        // the bridge itself has to hold this read until the write is answered
        read_and_compare("read_after_write", 1'b1, axi_bridge_pkg::TYPE_LINE, 32'h0000_0200,
                         4, got);
        check_equal("read_after_write", 128'hcafe_f00d_1357_9bdf_2468_ace0_0f1e_2d3c, got);
    endtask

    initial begin
        reset         = 1'b1;
        inst_rd_req   = 1'b0;
        inst_rd_type  = '0;
        inst_rd_addr  = '0;
        data_rd_req   = 1'b0;
        data_rd_type  = '0;
        data_rd_addr  = '0;
        data_wr_req   = 1'b0;
        data_wr_type  = '0;
        data_wr_addr  = '0;
        data_wr_wstrb = '0;
        data_wr_data  = '0;
        exp_arlen[0]  = '0;
        exp_arlen[1]  = '0;
        exp_awlen     = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 256; i++)
            shadow[i[7:0]] = u_mem.mem[i[7:0]];
        @(negedge clk);
        check_equal("after_reset", 128'h0f, 128'({arvalid, awvalid, wvalid, wlast,
                    inst_rd_rdy, data_rd_rdy, data_wr_rdy, write_buffer_empty}));
        @(posedge clk);
        #1;
        test_data_word_read();
        test_inst_line_read();
        test_line_write_readback();
        test_partial_word_write();
        test_dual_line_read();
        test_read_after_write();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/axi_bridge_pkg.sv
hw/axi_read_path.sv
hw/axi_write_path.sv
hw/cache_axi_bridge.sv
tests/axi_mem_model.sv
tests/tb_cache_axi_bridge.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --timescale 1ns/1ns --top-module tb_cache_axi_bridge \
    -f project.f -o tb_sim &&
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q '^RESULT: PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
